// ==== Bender.yml ====
package:
  name: core_pixel

sources:
  - include_dirs:
      - source
    files:
      - source/core_pixel_pkg.sv
      - source/cp_beat_sequencer.sv
      - source/cp_rotation_walker.sv
      - source/core_pixel.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_core_pixel_checks.sv
      - verification/tb_core_pixel.sv

// ==== filelist.f ====
+incdir+source
source/core_pixel_pkg.sv
source/cp_beat_sequencer.sv
source/cp_rotation_walker.sv
source/core_pixel.sv
verification/tb_clock_gen.sv
verification/tb_core_pixel_checks.sv
verification/tb_core_pixel.sv

// ==== source/core_pixel.sv ====
`timescale 1ns/1ps
`include "core_pixel_params.svh"
`default_nettype none

module core_pixel (
    input  wire                           I_CP_HCLK,
    input  wire                           I_CP_HRESET_N,
    input  wire                           dma_ready,
    input  wire                           stop,
    input  core_pixel_pkg::cp_rotation_e  rotation,
    input  wire                           direction,
    output core_pixel_pkg::cp_lane_addr_s lane_addr,
    output core_pixel_pkg::cp_rgb_addr_s  rgb_addr,
    output core_pixel_pkg::cp_phase_e     phase
);

    core_pixel_pkg::cp_beat_s beat;

    cp_beat_sequencer u_sequencer (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (dma_ready),
        .stop          (stop),
        .beat          (beat),
        .lane_addr     (lane_addr)
    );

    cp_rotation_walker u_walker (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .beat          (beat),
        .stop          (stop),
        .rotation      (rotation),
        .direction     (direction),
        .rgb_addr      (rgb_addr)
    );

    // tells the DMA engine whether it fills or drains
    assign phase = beat.phase;

endmodule

`default_nettype wire

// ==== source/core_pixel_params.svh ====
`ifndef CORE_PIXEL_PARAMS_SVH
`define CORE_PIXEL_PARAMS_SVH

`default_nettype none

// tile geometry
`define CP_TILE_SIDE        8
`define CP_TILE_PIXELS      64
`define CP_BYTES_PER_PIXEL  3

// bytes moved per AHB beat
`define CP_AHB_LANES        4

// colour byte inside one pixel
`define CP_OFFSET_B         0
`define CP_OFFSET_G         1
`define CP_OFFSET_R         2

`define CP_ADDR_W           8

`default_nettype wire

`endif

// ==== source/core_pixel_pkg.sv ====
`include "core_pixel_params.svh"
`default_nettype none

package core_pixel_pkg;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } cp_phase_e;

    typedef enum logic [1:0] {
        DEG_0   = 2'd0,
        DEG_90  = 2'd1,
        DEG_180 = 2'd2,
        DEG_270 = 2'd3
    } cp_rotation_e;

    typedef struct packed {
        logic [`CP_ADDR_W-1:0] lane3;
        logic [`CP_ADDR_W-1:0] lane2;
        logic [`CP_ADDR_W-1:0] lane1;
        logic [`CP_ADDR_W-1:0] lane0;
    } cp_lane_addr_s;

    typedef struct packed {
        logic [`CP_ADDR_W-1:0] r;
        logic [`CP_ADDR_W-1:0] g;
        logic [`CP_ADDR_W-1:0] b;
    } cp_rgb_addr_s;

    // one accepted beat, as seen by the walker
    typedef struct packed {
        cp_phase_e  phase;
        logic [5:0] index;
        logic       advance;
    } cp_beat_s;

endpackage

`default_nettype wire

// ==== source/cp_beat_sequencer.sv ====
`timescale 1ns/1ps
`include "core_pixel_params.svh"
`default_nettype none

module cp_beat_sequencer (
    input  wire                           I_CP_HCLK,
    input  wire                           I_CP_HRESET_N,
    input  wire                           dma_ready,
    input  wire                           stop,
    output core_pixel_pkg::cp_beat_s      beat,
    output core_pixel_pkg::cp_lane_addr_s lane_addr
);

    core_pixel_pkg::cp_phase_e phase_q;
    logic [5:0]                index_q;
    logic [`CP_ADDR_W-1:0]     lane_base_q;
    logic                      active;
    logic                      advance;
    logic                      last_beat;

    assign active = (phase_q == core_pixel_pkg::LOAD) || (phase_q == core_pixel_pkg::STORE);
    assign advance = dma_ready && !stop && active;
    assign last_beat = (index_q == 6'(`CP_TILE_PIXELS - 1));

    // phase register
    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N || stop)
        begin
            phase_q <= core_pixel_pkg::IDLE;
        end
        else if (phase_q == core_pixel_pkg::IDLE)
        begin
            // start beat is not counted
            if (dma_ready)
            begin
                phase_q <= core_pixel_pkg::LOAD;
            end
        end
        else if (advance && last_beat)
        begin
            if (phase_q == core_pixel_pkg::LOAD)
            begin
                phase_q <= core_pixel_pkg::STORE;
            end
            else
            begin
                phase_q <= core_pixel_pkg::LOAD;
            end
        end
    end

    // beat counter and lane base wrap to 0 after beat 63
    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N || stop)
        begin
            index_q     <= '0;
            lane_base_q <= '0;
        end
        else if (advance)
        begin
            index_q     <= index_q + 6'd1;
            lane_base_q <= lane_base_q + `CP_ADDR_W'(`CP_AHB_LANES);
        end
    end

    always_comb
    begin
        beat.phase   = phase_q;
        beat.index   = index_q;
        beat.advance = advance;
    end

    always_comb
    begin
        lane_addr = '0;
        if (!stop)
        begin
            lane_addr.lane0 = lane_base_q;
            lane_addr.lane1 = lane_base_q + `CP_ADDR_W'(1);
            lane_addr.lane2 = lane_base_q + `CP_ADDR_W'(2);
            lane_addr.lane3 = lane_base_q + `CP_ADDR_W'(3);
        end
    end

    // once running, only stop brings the phase back to idle
    a_phase_hold: assert property (@(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        (active && !stop) |=> (phase_q != core_pixel_pkg::IDLE))
        else $error("phase left LOAD/STORE without stop");

    // index drops to 0 exactly when the phase flips
    a_wrap_flip: assert property (@(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        (index_q != 6'd0 && !stop) |=> ((index_q == 6'd0) == (phase_q != $past(phase_q))))
        else $error("beat index wrapped without a phase flip");

endmodule

`default_nettype wire

// ==== source/cp_rotation_walker.sv ====
`timescale 1ns/1ps
`include "core_pixel_params.svh"
`default_nettype none

module cp_rotation_walker (
    input  wire                          I_CP_HCLK,
    input  wire                          I_CP_HRESET_N,
    input  core_pixel_pkg::cp_beat_s     beat,
    input  wire                          stop,
    input  core_pixel_pkg::cp_rotation_e rotation,
    input  wire                          direction,
    output core_pixel_pkg::cp_rgb_addr_s rgb_addr
);

    logic [5:0]                   row_0;
    logic [5:0]                   row_90;
    logic [5:0]                   row_180;
    logic [5:0]                   row_270;
    logic [2:0]                   col_90;
    logic [2:0]                   col_270;
    logic                         restart;
    logic                         step;
    logic                         col_step;
    core_pixel_pkg::cp_rotation_e eff_rot;
    logic [6:0]                   pix_sel;
    logic [`CP_ADDR_W-1:0]        pix_byte;

    assign step = beat.advance && (beat.phase == core_pixel_pkg::LOAD);
    assign restart = stop || (beat.phase != core_pixel_pkg::LOAD)
                     || (step && beat.index == 6'(`CP_TILE_PIXELS - 1));
    // last beat of a tile row
    assign col_step = (beat.index[2:0] == 3'(`CP_TILE_SIDE - 1));

    always_ff @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N || restart)
        begin
            row_0   <= '0;
            row_180 <= 6'(`CP_TILE_PIXELS - 1);
            row_90  <= 6'(`CP_TILE_PIXELS - `CP_TILE_SIDE);
            row_270 <= '0;
            col_90  <= '0;
            col_270 <= 3'(`CP_TILE_SIDE - 1);
        end
        else if (step)
        begin
            row_0   <= row_0 + 6'd1;
            row_180 <= row_180 - 6'd1;
            // 90/270 rows wrap mod 64 back to their start row after 8 beats
            row_90  <= row_90 - 6'(`CP_TILE_SIDE);
            row_270 <= row_270 + 6'(`CP_TILE_SIDE);
            if (col_step)
            begin
                col_90  <= col_90 + 3'd1;
                col_270 <= col_270 - 3'd1;
            end
        end
    end

    // direction swaps the two quarter turns
    always_comb
    begin
        eff_rot = rotation;
        if (direction)
        begin
            case (rotation)
                core_pixel_pkg::DEG_90:  eff_rot = core_pixel_pkg::DEG_270;
                core_pixel_pkg::DEG_270: eff_rot = core_pixel_pkg::DEG_90;
                default:                 eff_rot = rotation;
            endcase
        end
    end

    always_comb
    begin
        case (eff_rot)
            core_pixel_pkg::DEG_90:  pix_sel = {1'b0, row_90} + {4'b0, col_90};
            core_pixel_pkg::DEG_180: pix_sel = {1'b0, row_180};
            core_pixel_pkg::DEG_270: pix_sel = {1'b0, row_270} + {4'b0, col_270};
            default:                 pix_sel = {1'b0, row_0};
        endcase
    end

    assign pix_byte = `CP_ADDR_W'(pix_sel) * `CP_ADDR_W'(`CP_BYTES_PER_PIXEL);

    always_comb
    begin
        rgb_addr = '0;
        if (!stop)
        begin
            rgb_addr.b = pix_byte + `CP_ADDR_W'(`CP_OFFSET_B);
            rgb_addr.g = pix_byte + `CP_ADDR_W'(`CP_OFFSET_G);
            rgb_addr.r = pix_byte + `CP_ADDR_W'(`CP_OFFSET_R);
        end
    end

    // row and column walkers must stay in step so the sum never leaves the tile
    a_pixel_range: assert property (@(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        pix_sel < 7'(`CP_TILE_PIXELS))
        else $error("source pixel %0d outside the tile", pix_sel);

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic I_CP_HCLK,
    output logic I_CP_HRESET_N
);

    initial
    begin
        I_CP_HCLK = 1'b0;
        forever #20 I_CP_HCLK = ~I_CP_HCLK;
    end

    // reset released 2 ns after the second rising edge
    initial
    begin
        I_CP_HRESET_N = 1'b0;
        repeat (2) @(posedge I_CP_HCLK);
        #2 I_CP_HRESET_N = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/tb_core_pixel.sv ====
`timescale 1ns/1ps
`include "core_pixel_params.svh"
`default_nettype none

module tb_core_pixel;

    logic                          I_CP_HCLK;
    logic                          I_CP_HRESET_N;
    logic                          dma_ready;
    logic                          stop;
    core_pixel_pkg::cp_rotation_e  rotation;
    logic                          direction;
    core_pixel_pkg::cp_lane_addr_s lane_addr;
    core_pixel_pkg::cp_rgb_addr_s  rgb_addr;
    core_pixel_pkg::cp_phase_e     phase;
    logic [31:0]                   lfsr_state;
    logic                          hung;
    int                            tests_done;

    tb_clock_gen u_clock (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N)
    );

    core_pixel UUT (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (dma_ready),
        .stop          (stop),
        .rotation      (rotation),
        .direction     (direction),
        .lane_addr     (lane_addr),
        .rgb_addr      (rgb_addr),
        .phase         (phase)
    );

    bind core_pixel tb_core_pixel_checks u_checks (
        .I_CP_HCLK     (I_CP_HCLK),
        .I_CP_HRESET_N (I_CP_HRESET_N),
        .dma_ready     (dma_ready),
        .stop          (stop),
        .rotation      (rotation),
        .direction     (direction),
        .lane_addr     (lane_addr),
        .rgb_addr      (rgb_addr),
        .phase         (phase)
    );

    // right-shift Galois step with the old lsb as output bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge I_CP_HCLK);
        #2;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(posedge I_CP_HCLK);
        while (!I_CP_HRESET_N && n < 10)
        begin
            @(posedge I_CP_HCLK);
            n++;
        end
        #2;
        if (!I_CP_HRESET_N)
        begin
            hung = 1'b1;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic wait_phase(input core_pixel_pkg::cp_phase_e target);
        int n;
        n = 0;
        while (phase != target && n < 4)
        begin
            next_cycle();
            n++;
        end
        if (phase != target)
        begin
            hung = 1'b1;
            $display("timeout: phase never reached %s", target.name());
        end
    endtask

    // roughly one gap in four when gappy
    task automatic drive_beats(input int count, input logic gappy);
        int accepted;
        int n;
        accepted = 0;
        n = 0;
        while (accepted < count && n < count * 8 + 16)
        begin
            dma_ready = gappy ? (random_bits(2) != 0) : 1'b1;
            if (dma_ready && (phase == core_pixel_pkg::LOAD || phase == core_pixel_pkg::STORE))
                accepted++;
            next_cycle();
            n++;
        end
        dma_ready = 1'b0;
        if (accepted < count)
        begin
            hung = 1'b1;
            $display("timeout: only %0d of %0d beats accepted", accepted, count);
        end
    endtask

    task automatic run_tile(input int rot, input logic dir, input logic gappy);
        rotation  = core_pixel_pkg::cp_rotation_e'(rot);
        direction = dir;
        drive_beats(`CP_TILE_PIXELS, gappy);
        wait_phase(core_pixel_pkg::STORE);
        drive_beats(`CP_TILE_PIXELS, gappy);
        wait_phase(core_pixel_pkg::LOAD);
    endtask

    task automatic report_test(input string name);
        tests_done++;
        $display("test %0d %s finished, %0d failed checks so far", tests_done, name,
                 UUT.u_checks.error_count);
    endtask

    initial
    begin
        dma_ready  = 1'b0;
        stop       = 1'b0;
        rotation   = core_pixel_pkg::DEG_0;
        direction  = 1'b0;
        lfsr_state = 32'heed8_1c96;
        hung       = 1'b0;
        tests_done = 0;
        wait_reset_release();
        if (!hung)
        begin
            dma_ready = 1'b1;
            next_cycle();
            dma_ready = 1'b0;
            wait_phase(core_pixel_pkg::LOAD);
            report_test("reset and start");
        end
        if (!hung)
        begin
            run_tile(int'(random_bits(2)), random_bits(1) != 0, 1'b1);
            report_test("lanes with gaps");
        end
        for (int rot = 0; rot < 4 && !hung; rot++)
            run_tile(rot, 1'b0, 1'b1);
        if (!hung)
            report_test("rotations direction 0");
        for (int rot = 0; rot < 4 && !hung; rot++)
            run_tile(rot, 1'b1, 1'b0);
        if (!hung)
            report_test("rotations direction 1");
        if (!hung)
        begin
            run_tile(0, 1'b0, 1'b0);
            report_test("back to back phase flips");
        end
        if (!hung)
        begin
            rotation = core_pixel_pkg::DEG_90;
            drive_beats(20, 1'b0);
            stop      = 1'b1;
            dma_ready = 1'b1;
            next_cycle();
            stop      = 1'b0;
            dma_ready = 1'b0;
            wait_phase(core_pixel_pkg::IDLE);
            if (!hung)
                run_tile(int'(random_bits(2)), random_bits(1) != 0, 1'b1);
            report_test("stop and restart");
        end
        $display("tests finished %0d, failed checks %0d", tests_done,
                 UUT.u_checks.error_count);
        if (hung || UUT.u_checks.error_count != 0)
        begin
            $display("TEST FAILED");
        end
        else
        begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_core_pixel_checks.sv ====
`timescale 1ns/1ps
`include "core_pixel_params.svh"
`default_nettype none

module tb_core_pixel_checks (
    input  wire                           I_CP_HCLK,
    input  wire                           I_CP_HRESET_N,
    input  wire                           dma_ready,
    input  wire                           stop,
    input  core_pixel_pkg::cp_rotation_e  rotation,
    input  wire                           direction,
    input  core_pixel_pkg::cp_lane_addr_s lane_addr,
    input  core_pixel_pkg::cp_rgb_addr_s  rgb_addr,
    input  core_pixel_pkg::cp_phase_e     phase
);

    core_pixel_pkg::cp_phase_e     exp_phase;
    logic [5:0]                    exp_k;
    core_pixel_pkg::cp_lane_addr_s exp_lanes;
    core_pixel_pkg::cp_rgb_addr_s  exp_rgb;
    int                            error_count;

    // source pixel from row q = k div 8 and column c = k mod 8
    function automatic int source_pixel(input int rot, input logic dir, input int k);
        int q;
        int c;
        int r;
        q = k / `CP_TILE_SIDE;
        c = k % `CP_TILE_SIDE;
        r = rot;
        if (dir && (rot == 1 || rot == 3))
            r = 4 - rot;
        case (r)
            0:       return k;
            1:       return 56 - 8 * c + q;
            2:       return 63 - k;
            default: return 8 * c + 7 - q;
        endcase
    endfunction

    initial error_count = 0;

    // beat count from dma_ready and phase
    always @(posedge I_CP_HCLK)
    begin
        if (!I_CP_HRESET_N || stop)
        begin
            exp_phase <= core_pixel_pkg::IDLE;
            exp_k     <= '0;
        end
        else if (exp_phase == core_pixel_pkg::IDLE)
        begin
            if (dma_ready)
                exp_phase <= core_pixel_pkg::LOAD;
        end
        else if (dma_ready)
        begin
            exp_k <= exp_k + 6'd1;
            if (exp_k == 6'd63)
                exp_phase <= (exp_phase == core_pixel_pkg::LOAD) ? core_pixel_pkg::STORE
                                                                 : core_pixel_pkg::LOAD;
        end
    end

    always_comb
    begin
        int p;
        int base;
        p = source_pixel(int'(rotation), direction,
                         (exp_phase == core_pixel_pkg::LOAD) ? int'(exp_k) : 0);
        base = p * `CP_BYTES_PER_PIXEL;
        exp_rgb.b = 8'(base + `CP_OFFSET_B);
        exp_rgb.g = 8'(base + `CP_OFFSET_G);
        exp_rgb.r = 8'(base + `CP_OFFSET_R);
        exp_lanes.lane0 = 8'(4 * exp_k);
        exp_lanes.lane1 = 8'(4 * exp_k + 1);
        exp_lanes.lane2 = 8'(4 * exp_k + 2);
        exp_lanes.lane3 = 8'(4 * exp_k + 3);
    end

    a_phase: assert property (@(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        phase == exp_phase)
        else
        begin
            error_count++;
            $error("Error at %0t: phase %0d, expected %0d", $time, phase, exp_phase);
        end

    a_lanes: assert property (@(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        lane_addr == (stop ? '0 : exp_lanes))
        else
        begin
            error_count++;
            $error("Error at %0t: lanes %h, expected %h", $time, lane_addr, exp_lanes);
        end

    a_rgb: assert property (@(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        rgb_addr == (stop ? '0 : exp_rgb))
        else
        begin
            error_count++;
            $error("Error at %0t: rgb %h, expected %h", $time, rgb_addr, exp_rgb);
        end

    a_stop_idle: assert property (@(posedge I_CP_HCLK) disable iff (!I_CP_HRESET_N)
        stop |=> phase == core_pixel_pkg::IDLE)
        else
        begin
            error_count++;
            $error("Error at %0t: phase %0d after stop, expected idle", $time, phase);
        end

endmodule

`default_nettype wire
